//--- Makefile
# Verilator build and run of the SCCB master testbench

SIM := obj_dir/Vtb_sccb_master

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_sccb_master -f files.f

run: compile
	./$(SIM) | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/sccb_checker.sv
// SCCB master protocol checker
// concurrent assertions on the done pulse, the idle bus levels and
// request acceptance, bound into sccb_master

module sccb_checker
    import sccb_pkg::*;
(
    input logic        dri_clk,
    input logic        rst_n,
    input logic        i2c_exec,
    input logic        i2c_done,
    input logic        scl,
    input logic        sda_oe,
    input sccb_phase_e phase
);
    timeunit 1ns;
    timeprecision 100ps;

    done_pulse: assert property (@(posedge dri_clk) disable iff (!rst_n)
        i2c_done |=> !i2c_done)
        else $error("i2c_done stayed high for two cycles");

    // bus handed back to the pull-up whenever nothing runs
    idle_lines: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (phase == ph_idle) |-> (scl && !sda_oe))
        else $error("scl low or sda driven in idle");

    exec_start: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (phase == ph_idle && i2c_exec) |=> (phase == ph_sladdr))
        else $error("exec in idle did not start a transaction");

endmodule

bind sccb_master sccb_checker u_checker (
    .dri_clk  (dri_clk),
    .rst_n    (rst_n),
    .i2c_exec (i2c_exec),
    .i2c_done (i2c_done),
    .scl      (scl),
    .sda_oe   (drive.sda_oe),
    .phase    (step.phase)
);

//--- dv/tb_sccb_master.sv
// SCCB master testbench
// LCG requests, a bus decoder with a slave memory model,
// checks of every bus byte and every read value

`include "sccb_settings.svh"

module tb_sccb_master;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int tok_start = 'h200;        // byte tokens are {ack, data}
    localparam int tok_stop  = 'h400;
    localparam int max_wait  = 2000;

    logic        dri_clk;
    logic        rst_n;
    logic        i2c_exec;
    logic        bit_ctrl;
    logic        i2c_rh_wl;
    logic [15:0] i2c_addr;
    logic [7:0]  i2c_data_w;
    logic [7:0]  i2c_data_r;
    logic        i2c_done;
    logic        scl;
    wire         sda;

    logic        slave_low;                  // slave pulls sda down
    logic        mode16;                     // address width of the slave
    logic        prev_scl;
    logic        prev_sda;
    logic        rd_dir;
    logic [8:0]  shreg;
    logic [7:0]  rd_val;
    logic [15:0] sl_addr;
    int          nbits;
    int          nbytes;                     // bytes since the last start
    int          bus_q[$];
    logic [7:0]  slave_mem[logic [15:0]];
    logic [7:0]  exp_mem[logic [15:0]];
    logic [31:0] lcg_state;
    int          errors;
    int          tests;
    int          mark_err;

    pullup (sda);
    assign sda = slave_low ? 1'b0 : 1'bz;

    sccb_master UUT (.*);

    initial begin
        dri_clk = 1'b0;
        forever #2 dri_clk = ~dri_clk;
    end

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("Mismatch %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic close_test(input string name);
        $display("test %-10s %0d errors", name, errors - mark_err);
        mark_err = errors;
        tests    = tests + 1;
    endtask

    // --------------------
    // bus decoder and slave, sampled mid-cycle
    always @(negedge dri_clk) begin
        if (prev_scl && scl && (prev_sda != sda)) begin
            bus_q.push_back(sda ? tok_stop : tok_start);
            nbits  = 0;
            nbytes = 0;
        end else if (!prev_scl && scl) begin
            shreg = {shreg[7:0], sda};
            nbits = nbits + 1;
            if (nbits == 9) begin
                bus_q.push_back(int'({shreg[0], shreg[8:1]}));
                if (nbytes == 0) begin
                    rd_dir = shreg[1];                       // r/w bit
                    rd_val = slave_mem.exists(sl_addr) ? slave_mem[sl_addr] : ~sl_addr[7:0];
                    if (!rd_dir)
                        sl_addr = '0;
                end else if (!rd_dir && nbytes <= (mode16 ? 2 : 1)) begin
                    sl_addr = {sl_addr[7:0], shreg[8:1]};    // address bytes, hi first
                end else if (!rd_dir) begin
                    slave_mem[sl_addr] = shreg[8:1];
                end
                nbits  = 0;
                nbytes = nbytes + 1;
            end
        end else if (prev_scl && !scl) begin
            // next read bit goes out while scl is low
            slave_low = rd_dir && (nbytes == 1) && (nbits < 8) && !rd_val[7 - nbits];
        end
        prev_scl = scl;
        prev_sda = sda;
    end

    // --------------------
    // one transaction, optional exec with other fields mid-way
    task automatic run_transaction(input logic rw, input logic m16, input logic [15:0] a,
                                   input logic [7:0] d, input logic disturb);
        logic [15:0] ea;
        logic [7:0]  exp_rd;
        int          exp_q[$];
        int          n;
        ea     = m16 ? a : {8'h00, a[7:0]};
        exp_rd = exp_mem.exists(ea) ? exp_mem[ea] : ~ea[7:0];
        exp_q.push_back(tok_start);
        exp_q.push_back('h100 | {`SCCB_SLAVE_ADDR, 1'b0});
        if (m16)
            exp_q.push_back('h100 | a[15:8]);
        exp_q.push_back('h100 | a[7:0]);
        if (rw) begin
            exp_q.push_back(tok_stop);
            exp_q.push_back(tok_start);
            exp_q.push_back('h100 | {`SCCB_SLAVE_ADDR, 1'b1});
            exp_q.push_back('h100 | exp_rd);                 // nack high
        end else begin
            exp_q.push_back('h100 | d);
            exp_mem[ea] = d;
        end
        exp_q.push_back(tok_stop);
        bus_q.delete();
        mode16 = m16;
        {i2c_rh_wl, bit_ctrl, i2c_addr, i2c_data_w} = {rw, m16, a, d};
        i2c_exec = 1'b1;
        n = 0;
        do begin
            @(negedge dri_clk);
            n = n + 1;
            i2c_exec = disturb && (n >= 100) && (n < 104);
            if (disturb && n == 100)
                {i2c_rh_wl, bit_ctrl, i2c_addr, i2c_data_w} = ~{rw, m16, a, d};
        end while (!i2c_done && n < max_wait);
        if (!i2c_done) begin
            errors = errors + 1;
            $display("Timeout: no i2c_done within %0d cycles", max_wait);
        end else begin
            compare("sda token count", bus_q.size(), exp_q.size());
            foreach (exp_q[i])
                if (i < bus_q.size())
                    compare($sformatf("sda token %0d", i), bus_q[i], exp_q[i]);
            if (rw)
                compare("i2c_data_r", i2c_data_r, exp_rd);
            else
                compare("slave_mem", slave_mem[ea], d);
        end
    endtask

    initial begin
        logic [15:0] r;
        {i2c_exec, bit_ctrl, i2c_rh_wl, i2c_addr, i2c_data_w} = '0;
        {slave_low, mode16, rd_dir, prev_scl, prev_sda} = 5'b00011;
        sl_addr   = '0;
        shreg     = '0;
        nbits     = 0;
        nbytes    = 0;
        lcg_state = 32'd83;
        errors    = 0;
        tests     = 0;
        mark_err  = 0;
        rst_n     = 1'b0;
        repeat (2) @(negedge dri_clk);
        rst_n = 1'b1;
        @(negedge dri_clk);
        compare("scl", scl, 1);
        compare("sda", sda, 1);
        compare("i2c_done", i2c_done, 0);
        compare("i2c_data_r", i2c_data_r, 0);
        close_test("reset");
        run_transaction(1'b0, 1'b0, 16'h1234, 8'h5a, 1'b0);
        close_test("write8");
        run_transaction(1'b0, 1'b1, 16'h8642, 8'hc3, 1'b0);
        close_test("write16");
        run_transaction(1'b1, 1'b0, 16'h1234, 8'h00, 1'b0);
        run_transaction(1'b1, 1'b1, 16'h8642, 8'h00, 1'b0);
        run_transaction(1'b1, 1'b0, 16'h0077, 8'h00, 1'b0);     // never written
        close_test("read");
        repeat (40) begin
            r = lcg_next();
            run_transaction(r[0], r[1], {7'h12, r[2], 6'h30, r[4:3]}, r[15:8], 1'b0);
        end
        close_test("random");
        run_transaction(1'b0, 1'b1, 16'h2468, 8'h99, 1'b1);
        run_transaction(1'b1, 1'b1, 16'h2468, 8'h00, 1'b1);
        close_test("exec_busy");
        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- files.f
+incdir+verilog
verilog/sccb_pkg.sv
verilog/sccb_sequencer.sv
verilog/sccb_line_driver.sv
verilog/sccb_read_capture.sv
verilog/sccb_master.sv
dv/sccb_checker.sv
dv/tb_sccb_master.sv

//--- verilog/sccb_line_driver.sv
// SCCB line driver
// turns the phase step into SCL and SDA levels: start, stop,
// restart, eight bits per byte and the ack slot
// each bit is four cycles with data set while SCL is low

`include "sccb_settings.svh"

module sccb_line_driver
    import sccb_pkg::*;
(
    input  logic        dri_clk,
    input  logic        rst_n,
    input  phase_step_t step,
    input  sccb_req_t   req,
    output line_drive_t drive
);

    localparam logic [`SCCB_CNT_W-1:0] sl_byte_at  = 4;    // byte start in sladdr
    localparam logic [`SCCB_CNT_W-1:0] rs_start_at = 26;   // restart in addr_rd
    localparam logic [`SCCB_CNT_W-1:0] rs_byte_at  = 28;   // byte start in addr_rd
    localparam logic [`SCCB_CNT_W-1:0] ack_at      = 32;   // ack slot within a byte

    line_drive_t            drive_nxt;
    logic                   in_byte;
    logic                   rd_byte;
    logic [`SCCB_CNT_W-1:0] bit_off;
    logic [7:0]             tx_byte;

    always_comb begin
        drive_nxt = drive;                        // hold unless a step changes it
        in_byte   = 1'b0;
        rd_byte   = 1'b0;
        bit_off   = step.cnt;
        tx_byte   = 8'hff;

        // --------------------
        // framing per phase
        case (step.phase)
            ph_idle: begin
                drive_nxt = '{scl: 1'b1, sda_out: 1'b1, sda_oe: 1'b0};
            end
            ph_sladdr: begin
                if (step.cnt == 0) begin
                    drive_nxt.sda_oe  = 1'b1;
                    drive_nxt.sda_out = 1'b1;
                end else if (step.cnt == 1) begin
                    drive_nxt.sda_out = 1'b0;     // start
                end else if (step.cnt == 3) begin
                    drive_nxt.scl = 1'b0;
                end else if (step.cnt >= sl_byte_at) begin
                    in_byte = 1'b1;
                    bit_off = step.cnt - sl_byte_at;
                    tx_byte = {`SCCB_SLAVE_ADDR, 1'b0};   // write bit
                end
            end
            ph_addr16: begin
                in_byte = 1'b1;
                tx_byte = req.addr.bytes.hi;
            end
            ph_addr8: begin
                in_byte = 1'b1;
                tx_byte = req.addr.bytes.lo;
            end
            ph_data_wr: begin
                in_byte = 1'b1;
                tx_byte = req.data_w;
            end
            ph_addr_rd: begin
                if (step.cnt == 0) begin
                    drive_nxt.sda_oe  = 1'b1;
                    drive_nxt.sda_out = 1'b0;
                end else if (step.cnt == 1) begin
                    drive_nxt.scl = 1'b1;
                end else if (step.cnt == 3) begin
                    drive_nxt.sda_out = 1'b1;     // stop before the restart
                end else if (step.cnt == rs_start_at) begin
                    drive_nxt.sda_out = 1'b0;     // restart
                end else if (step.cnt == rs_start_at + 1'b1) begin
                    drive_nxt.scl = 1'b0;
                end else if (step.cnt >= rs_byte_at) begin
                    in_byte = 1'b1;
                    bit_off = step.cnt - rs_byte_at;
                    tx_byte = {`SCCB_SLAVE_ADDR, 1'b1};   // read bit
                end
            end
            ph_data_rd: begin
                in_byte = 1'b1;
                rd_byte = 1'b1;
            end
            ph_stop: begin
                if (step.cnt == 0) begin
                    drive_nxt.sda_oe  = 1'b1;
                    drive_nxt.sda_out = 1'b0;
                end else if (step.cnt == 1) begin
                    drive_nxt.scl = 1'b1;
                end else if (step.cnt == 3) begin
                    drive_nxt.sda_out = 1'b1;     // stop
                end else if (step.last) begin
                    drive_nxt.sda_oe = 1'b0;      // hand the line back to the pull-up
                end
            end
            default: ;
        endcase

        // --------------------
        // bit slots of a byte
        if (in_byte) begin
            case (bit_off[1:0])
                2'd0: begin
                    if (bit_off < ack_at) begin
                        drive_nxt.sda_oe  = !rd_byte;
                        drive_nxt.sda_out = rd_byte | tx_byte[3'd7 - bit_off[4:2]];
                    end else begin
                        drive_nxt.sda_oe  = rd_byte;  // nack on read, released ack
                        drive_nxt.sda_out = 1'b1;
                    end
                end
                2'd1: drive_nxt.scl = 1'b1;
                2'd3: drive_nxt.scl = 1'b0;
                default: ;
            endcase
        end
    end

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n)
            drive <= '{scl: 1'b1, sda_out: 1'b1, sda_oe: 1'b0};
        else
            drive <= drive_nxt;
    end

endmodule

//--- verilog/sccb_master.sv
// SCCB master top level
// one bus transaction per exec request, open-drain SDA pad

`include "sccb_settings.svh"

module sccb_master
    import sccb_pkg::*;
(
    input  logic        dri_clk,
    input  logic        rst_n,
    input  logic        i2c_exec,
    input  logic        bit_ctrl,
    input  logic        i2c_rh_wl,
    input  logic [15:0] i2c_addr,
    input  logic [7:0]  i2c_data_w,
    output logic [7:0]  i2c_data_r,
    output logic        i2c_done,
    output logic        scl,
    inout  wire         sda
);

    phase_step_t step;
    sccb_req_t   req;
    line_drive_t drive;

    sccb_sequencer u_sequencer (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .step       (step),
        .req        (req),
        .i2c_done   (i2c_done)
    );

    sccb_line_driver u_line_driver (
        .dri_clk (dri_clk),
        .rst_n   (rst_n),
        .step    (step),
        .req     (req),
        .drive   (drive)
    );

    sccb_read_capture u_read_capture (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .step       (step),
        .sda_in     (sda),
        .i2c_data_r (i2c_data_r)
    );

    // --------------------
    // pins
    assign scl = drive.scl;
    assign sda = drive.sda_oe ? drive.sda_out : 1'bz;   // released otherwise

endmodule

//--- verilog/sccb_pkg.sv
// SCCB master types
// phase encoding, latched request, word address views and pin drive

`include "sccb_settings.svh"

package sccb_pkg;

    // --------------------
    // transaction phases
    typedef enum logic [2:0] {
        ph_idle,
        ph_sladdr,
        ph_addr16,
        ph_addr8,
        ph_data_wr,
        ph_addr_rd,
        ph_data_rd,
        ph_stop
    } sccb_phase_e;

    // word address, whole or split into the two bus bytes
    typedef union packed {
        logic [15:0] word;            // as given on i2c_addr
        struct packed {
            logic [7:0] hi;           // sent in addr16
            logic [7:0] lo;           // sent in addr8
        } bytes;
    } word_addr_u;

    typedef struct packed {
        logic       rh_wl;            // 1 read, 0 write
        logic       bit_ctrl;         // 1 for 16-bit word address
        word_addr_u addr;
        logic [7:0] data_w;
    } sccb_req_t;

    typedef struct packed {
        sccb_phase_e             phase;
        logic [`SCCB_CNT_W-1:0]  cnt;     // cycle within the phase
        logic                    last;    // final cycle of the phase
    } phase_step_t;

    typedef struct packed {
        logic scl;
        logic sda_out;
        logic sda_oe;                 // sda driven when high
    } line_drive_t;

endpackage

//--- verilog/sccb_read_capture.sv
// SCCB read capture
// shifts in the eight read bits as SCL rises and presents the
// byte on i2c_data_r when the read phase ends

module sccb_read_capture
    import sccb_pkg::*;
(
    input  logic        dri_clk,
    input  logic        rst_n,
    input  phase_step_t step,
    input  logic        sda_in,
    output logic [7:0]  i2c_data_r
);

    logic [7:0] shift_q;
    logic       sample;

    // second cycle of each bit, before the ack slot
    assign sample = (step.phase == ph_data_rd) && (step.cnt[1:0] == 2'd1) &&
                    (step.cnt < 'd32);

    always_ff @(posedge dri_clk) begin
        if (sample)
            shift_q <= {shift_q[6:0], sda_in};    // msb first
    end

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n)
            i2c_data_r <= 8'h00;
        else if ((step.phase == ph_data_rd) && step.last)
            i2c_data_r <= shift_q;                // held until the next read
    end

endmodule

//--- verilog/sccb_sequencer.sv
// SCCB transaction sequencer
// latches one request in idle, walks the bus phases in order and
// counts the cycles of each phase; pulses i2c_done after stop

`include "sccb_settings.svh"

module sccb_sequencer
    import sccb_pkg::*;
(
    input  logic        dri_clk,
    input  logic        rst_n,
    input  logic        i2c_exec,
    input  logic        bit_ctrl,
    input  logic        i2c_rh_wl,
    input  logic [15:0] i2c_addr,
    input  logic [7:0]  i2c_data_w,
    output phase_step_t step,
    output sccb_req_t   req,
    output logic        i2c_done
);

    sccb_phase_e            phase_q;
    sccb_phase_e            phase_nxt;
    logic [`SCCB_CNT_W-1:0] cnt_q;
    logic [`SCCB_CNT_W-1:0] len;
    logic                   last;

    // --------------------
    // phase length and end
    always_comb begin
        case (phase_q)
            ph_sladdr:  len = `SCCB_LEN_SLADDR;
            ph_addr_rd: len = `SCCB_LEN_RESTART;
            ph_stop:    len = `SCCB_LEN_STOP;
            default:    len = `SCCB_LEN_BYTE;     // address and data bytes
        endcase
    end

    assign last = (phase_q != ph_idle) && (cnt_q == len - 1'b1);

    // --------------------
    // next phase, taken when last is high
    always_comb begin
        case (phase_q)
            ph_sladdr:  phase_nxt = req.bit_ctrl ? ph_addr16 : ph_addr8;
            ph_addr16:  phase_nxt = ph_addr8;
            ph_addr8:   phase_nxt = req.rh_wl ? ph_addr_rd : ph_data_wr;
            ph_data_wr: phase_nxt = ph_stop;
            ph_addr_rd: phase_nxt = ph_data_rd;
            ph_data_rd: phase_nxt = ph_stop;
            default:    phase_nxt = ph_idle;      // stop and idle
        endcase
    end

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q  <= ph_idle;
            cnt_q    <= '0;
            i2c_done <= 1'b0;
        end else begin
            i2c_done <= (phase_q == ph_stop) && last;
            if (phase_q == ph_idle) begin
                cnt_q <= '0;
                if (i2c_exec)
                    phase_q <= ph_sladdr;
            end else if (last) begin
                phase_q <= phase_nxt;
                cnt_q   <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // request latch, only loaded when a transaction starts
    always_ff @(posedge dri_clk) begin
        if ((phase_q == ph_idle) && i2c_exec) begin
            req.rh_wl     <= i2c_rh_wl;
            req.bit_ctrl  <= bit_ctrl;
            req.addr.word <= i2c_addr;
            req.data_w    <= i2c_data_w;
        end
    end

    assign step = '{phase: phase_q, cnt: cnt_q, last: last};

endmodule

//--- verilog/sccb_settings.svh
// SCCB master settings
// slave address and the cycle length of every bus phase,
// counted in dri_clk cycles at four cycles per SCL period

`ifndef SCCB_SETTINGS_SVH
`define SCCB_SETTINGS_SVH

// --------------------
// bus target
`define SCCB_SLAVE_ADDR   7'h50       // 7-bit slave address

// --------------------
// phase lengths
`define SCCB_LEN_SLADDR   40          // start + address byte + ack
`define SCCB_LEN_BYTE     36          // eight bits + ack slot
`define SCCB_LEN_RESTART  64          // stop, gap, start, address byte + ack
`define SCCB_LEN_STOP     17          // stop condition and idle gap
`define SCCB_CNT_W        7           // phase counter width

`endif
